// File: verilog/trdb_settings.svh
// Widths and buffer depths of the trace encoder

`ifndef TRDB_SETTINGS_SVH
`define TRDB_SETTINGS_SVH

// Instruction fields
`define TRDB_XLEN 32
`define TRDB_PRIVLEN 2
`define TRDB_CAUSELEN 5

// Packet vector and its length field
`define TRDB_PACKET_LEN 72
`define TRDB_PACKET_HEADER_LEN 7

// Branch map capacity and the width of its count
`define TRDB_BRANCH_MAP_LEN 31
`define TRDB_BRANCH_CNT_LEN 5

// Stream buffer depths
`define TRDB_IN_STAGES 2
`define TRDB_PACKET_STAGES 4

`endif

// File: verilog/trdb_pkg.sv
// Trace encoder types: packet format codes, retired instruction,
// packet request and buffered packet

`include "trdb_settings.svh"

package trdb_pkg;

    typedef enum logic [1:0] {
        F_BRANCH_FULL = 2'd0,
        F_BRANCH_DIFF = 2'd1,
        F_ADDR_ONLY   = 2'd2,
        F_SYNC        = 2'd3
    } trdb_format_t;

    typedef enum logic [1:0] {
        SF_START     = 2'd0,
        SF_EXCEPTION = 2'd1,
        SF_CONTEXT   = 2'd2,
        SF_UNDEF     = 2'd3
    } trdb_subformat_t;

    typedef logic [`TRDB_PACKET_LEN-1:0]        trdb_bits_t;
    typedef logic [`TRDB_PACKET_HEADER_LEN-1:0] trdb_len_t;

    // One retired instruction as reported by the core
    typedef struct packed {
        logic [`TRDB_XLEN-1:0]     iaddr;
        logic [`TRDB_PRIVLEN-1:0]  priv;
        logic                      is_branch;
        logic                      taken;
        logic                      is_jump;
        logic                      exception;
        logic                      interrupt;
        logic [`TRDB_CAUSELEN-1:0] cause;
    } trdb_instr_t;

    typedef struct packed {
        trdb_bits_t bits;
        trdb_len_t  len;
    } trdb_packet_t;

    typedef struct packed {
        trdb_format_t              format;
        trdb_subformat_t           subformat;
        logic [`TRDB_XLEN-1:0]     iaddr;
        logic [`TRDB_PRIVLEN-1:0]  priv;
        logic                      is_branch;
        logic                      interrupt;
        logic [`TRDB_CAUSELEN-1:0] cause;
        // Branch-full packet carries iaddr after the map
        logic                      with_addr;
    } trdb_pkt_req_t;

endpackage

// File: verilog/trdb_stream_fifo.sv
// Valid/grant stream FIFO with a configurable payload type

module trdb_stream_fifo #(
    parameter type         payload_t = logic,
    parameter int unsigned Depth     = 2
) (
    input  logic     clk_i,
    input  logic     rst_ni,
    input  payload_t data_i,
    input  logic     valid_i,
    output logic     grant_o,
    output payload_t data_o,
    output logic     valid_o,
    input  logic     grant_i
);
    localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;
    localparam int unsigned CntW = $clog2(Depth + 1);
    localparam logic [PtrW-1:0] LastPtr = PtrW'(Depth - 1);
    localparam logic [CntW-1:0] FullCnt = CntW'(Depth);

    payload_t        mem_q [Depth];
    logic [PtrW-1:0] rd_ptr_q, wr_ptr_q;
    logic [CntW-1:0] count_q;
    logic            push, pop;

    assign grant_o = (count_q != FullCnt);
    assign valid_o = (count_q != '0);
    assign push    = valid_i & grant_o;
    assign pop     = valid_o & grant_i;
    assign data_o  = mem_q[rd_ptr_q];

    function automatic logic [PtrW-1:0] next_ptr(input logic [PtrW-1:0] ptr);
        return (ptr == LastPtr) ? '0 : ptr + 1'b1;
    endfunction

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) wr_ptr_q <= next_ptr(wr_ptr_q);
            if (pop) rd_ptr_q <= next_ptr(rd_ptr_q);
            // Simultaneous push and pop leaves the occupancy unchanged
            if (push && !pop) count_q <= count_q + 1'b1;
            else if (pop && !push) count_q <= count_q - 1'b1;
        end
    end

endmodule

// File: verilog/trdb_branch_map.sv
// Branch outcome map with count, full flag and flush

`include "trdb_settings.svh"

module trdb_branch_map (
    input  logic                                clk_i,
    input  logic                                rst_ni,
    input  logic                                shift_valid_i,
    input  logic                                taken_i,
    input  logic                                flush_i,
    output logic [`TRDB_BRANCH_MAP_LEN-1:0]     map_o,
    output logic [`TRDB_BRANCH_CNT_LEN-1:0]     cnt_o,
    output logic                                full_o
);
    localparam logic [`TRDB_BRANCH_CNT_LEN-1:0] FullCnt = `TRDB_BRANCH_MAP_LEN;

    logic [`TRDB_BRANCH_MAP_LEN-1:0] map_q;
    logic [`TRDB_BRANCH_CNT_LEN-1:0] cnt_q;

    assign map_o  = map_q;
    assign cnt_o  = cnt_q;
    assign full_o = (cnt_q == FullCnt);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            map_q <= '0;
            cnt_q <= '0;
        end else if (flush_i) begin
            // Flush wins over an append in the same cycle
            map_q <= '0;
            cnt_q <= '0;
        end else if (shift_valid_i && !full_o) begin
            // Oldest outcome sits in bit 0
            map_q[cnt_q] <= taken_i;
            cnt_q        <= cnt_q + 1'b1;
        end
    end

endmodule

// File: verilog/trdb_priority.sv
// Packet decision FSM: pops retired instructions, feeds the branch map
// and requests packets from the emitter

`include "trdb_settings.svh"

module trdb_priority (
    input  logic                            clk_i,
    input  logic                            rst_ni,
    input  trdb_pkg::trdb_instr_t           instr_i,
    input  logic                            instr_valid_i,
    output logic                            instr_pop_o,
    input  logic [`TRDB_BRANCH_CNT_LEN-1:0] map_cnt_i,
    input  logic                            map_full_i,
    output logic                            shift_valid_o,
    output logic                            taken_o,
    output trdb_pkg::trdb_pkt_req_t         req_o,
    output logic                            req_valid_o,
    input  logic                            emit_ready_i
);
    import trdb_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        FLUSH_WAIT,
        EXC_SECOND
    } state_e;

    state_e      state_q, state_d;
    logic        first_q, first_d;
    logic        exc_pend_q, exc_pend_d;
    logic        save_instr;
    trdb_instr_t instr_q;
    trdb_instr_t cur_instr;

    // The second exception packet describes the instruction popped earlier
    assign cur_instr = (state_q == EXC_SECOND) ? instr_q : instr_i;
    assign taken_o   = instr_i.taken;

    always_comb begin
        state_d       = state_q;
        first_d       = first_q;
        exc_pend_d    = exc_pend_q;
        save_instr    = 1'b0;
        instr_pop_o   = 1'b0;
        shift_valid_o = 1'b0;
        req_valid_o   = 1'b0;

        req_o.format    = F_SYNC;
        req_o.subformat = SF_START;
        req_o.iaddr     = cur_instr.iaddr;
        req_o.priv      = cur_instr.priv;
        req_o.is_branch = cur_instr.is_branch;
        req_o.interrupt = cur_instr.interrupt;
        req_o.cause     = cur_instr.cause;
        req_o.with_addr = 1'b0;

        case (state_q)
            IDLE: begin
                if (emit_ready_i) begin
                    if (map_full_i) begin
                        // Map filled by the previous branch
                        req_valid_o  = 1'b1;
                        req_o.format = F_BRANCH_FULL;
                        state_d      = FLUSH_WAIT;
                    end else if (instr_valid_i) begin
                        instr_pop_o = 1'b1;
                        first_d     = 1'b0;
                        if (instr_i.exception) begin
                            req_valid_o = 1'b1;
                            state_d     = FLUSH_WAIT;
                            if (map_cnt_i != '0) begin
                                // Drain pending branches before the sync packet
                                req_o.format    = F_BRANCH_FULL;
                                req_o.with_addr = 1'b1;
                                exc_pend_d      = 1'b1;
                                save_instr      = 1'b1;
                            end else begin
                                req_o.subformat = SF_EXCEPTION;
                            end
                        end else if (first_q) begin
                            req_valid_o = 1'b1;
                            state_d     = FLUSH_WAIT;
                        end else if (instr_i.is_jump) begin
                            req_valid_o = 1'b1;
                            state_d     = FLUSH_WAIT;
                            if (map_cnt_i != '0) begin
                                req_o.format    = F_BRANCH_FULL;
                                req_o.with_addr = 1'b1;
                            end else begin
                                req_o.format = F_ADDR_ONLY;
                            end
                        end else if (instr_i.is_branch) begin
                            shift_valid_o = 1'b1;
                        end
                    end
                end
            end
            FLUSH_WAIT: begin
                state_d = exc_pend_q ? EXC_SECOND : IDLE;
            end
            EXC_SECOND: begin
                if (emit_ready_i) begin
                    req_valid_o     = 1'b1;
                    req_o.subformat = SF_EXCEPTION;
                    exc_pend_d      = 1'b0;
                    state_d         = FLUSH_WAIT;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (save_instr) begin
            instr_q <= instr_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q    <= IDLE;
            first_q    <= 1'b1;
            exc_pend_q <= 1'b0;
        end else begin
            state_q    <= state_d;
            first_q    <= first_d;
            exc_pend_q <= exc_pend_d;
        end
    end

endmodule

// File: verilog/trdb_packet_emitter.sv
// Packet assembly for each requested format, packet buffer and
// branch map flush

`include "trdb_settings.svh"

module trdb_packet_emitter (
    input  logic                            clk_i,
    input  logic                            rst_ni,
    input  trdb_pkg::trdb_pkt_req_t         req_i,
    input  logic                            req_valid_i,
    input  logic [`TRDB_BRANCH_MAP_LEN-1:0] branch_map_i,
    input  logic [`TRDB_BRANCH_CNT_LEN-1:0] branch_map_cnt_i,
    output logic                            emit_ready_o,
    output logic                            branch_map_flush_o,
    output trdb_pkg::trdb_packet_t          packet_o,
    output logic                            packet_valid_o,
    input  logic                            packet_grant_i
);
    import trdb_pkg::*;

    localparam int SyncStartLen = 2 + 2 + `TRDB_PRIVLEN + 1 + `TRDB_XLEN;
    localparam int SyncExcLen   = SyncStartLen + `TRDB_CAUSELEN + 1;
    localparam int AddrOnlyLen  = 2 + `TRDB_XLEN;

    logic [`TRDB_BRANCH_CNT_LEN-1:0] branch_off;
    logic [`TRDB_BRANCH_MAP_LEN-1:0] map_mask;
    trdb_bits_t                      map_field;
    trdb_bits_t                      addr_field;
    trdb_packet_t                    packet;
    logic                            flush_q;

    // Map field is rounded up to one of the fixed widths
    always_comb begin
        if (branch_map_cnt_i <= 1) branch_off = 5'd1;
        else if (branch_map_cnt_i <= 9) branch_off = 5'd9;
        else if (branch_map_cnt_i <= 17) branch_off = 5'd17;
        else if (branch_map_cnt_i <= 25) branch_off = 5'd25;
        else branch_off = 5'd31;
    end

    // Wraps to all ones for the full 31 bit width
    assign map_mask   = ({{(`TRDB_BRANCH_MAP_LEN-1){1'b0}}, 1'b1} << branch_off) - 1'b1;
    assign map_field  = trdb_bits_t'(branch_map_i & map_mask);
    assign addr_field = trdb_bits_t'(req_i.iaddr);

    always_comb begin
        packet           = '0;
        packet.bits[1:0] = req_i.format;

        case (req_i.format)
            F_BRANCH_FULL: begin
                packet.bits[6:2] = branch_map_cnt_i;
                packet.bits      = packet.bits | (map_field << 7);
                if (req_i.with_addr) begin
                    packet.bits = packet.bits | (addr_field << (7 + branch_off));
                    packet.len  = trdb_len_t'(9 + branch_off + `TRDB_XLEN);
                end else begin
                    packet.len  = trdb_len_t'(9 + branch_off);
                end
            end
            F_ADDR_ONLY: begin
                packet.bits[2+:`TRDB_XLEN] = req_i.iaddr;
                packet.len                 = trdb_len_t'(AddrOnlyLen);
            end
            F_SYNC: begin
                if (req_i.subformat == SF_EXCEPTION) begin
                    packet.bits[2+:SyncExcLen-2] = {req_i.interrupt, req_i.cause,
                                                    req_i.iaddr, req_i.is_branch,
                                                    req_i.priv, req_i.subformat};
                    packet.len = trdb_len_t'(SyncExcLen);
                end else begin
                    packet.bits[2+:SyncStartLen-2] = {req_i.iaddr, req_i.is_branch,
                                                      req_i.priv, req_i.subformat};
                    packet.len = trdb_len_t'(SyncStartLen);
                end
            end
            // Differential address is never requested
            default: packet.len = '0;
        endcase
    end

    trdb_stream_fifo #(
        .payload_t(trdb_packet_t),
        .Depth    (`TRDB_PACKET_STAGES)
    ) u_packet_fifo (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .data_i (packet),
        .valid_i(req_valid_i),
        .grant_o(emit_ready_o),
        .data_o (packet_o),
        .valid_o(packet_valid_o),
        .grant_i(packet_grant_i)
    );

    // Every emitted packet consumes the map contents
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            flush_q <= 1'b0;
        end else begin
            flush_q <= req_valid_i;
        end
    end

    assign branch_map_flush_o = flush_q;

endmodule

// File: verilog/trdb_tracer.sv
// Trace encoder top: input buffer, packet decision, branch map and emitter

`include "trdb_settings.svh"

module trdb_tracer (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  trdb_pkg::trdb_instr_t  instr_i,
    input  logic                   instr_valid_i,
    output logic                   instr_ready_o,
    output trdb_pkg::trdb_packet_t packet_o,
    output logic                   packet_valid_o,
    input  logic                   packet_grant_i
);
    import trdb_pkg::*;

    trdb_instr_t                     fifo_instr;
    logic                            fifo_valid;
    logic                            instr_pop;
    logic                            shift_valid;
    logic                            taken;
    logic                            map_flush;
    logic [`TRDB_BRANCH_MAP_LEN-1:0] map_bits;
    logic [`TRDB_BRANCH_CNT_LEN-1:0] map_cnt;
    logic                            map_full;
    trdb_pkt_req_t                   req;
    logic                            req_valid;
    logic                            emit_ready;

    trdb_stream_fifo #(
        .payload_t(trdb_instr_t),
        .Depth    (`TRDB_IN_STAGES)
    ) u_in_fifo (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .data_i (instr_i),
        .valid_i(instr_valid_i),
        .grant_o(instr_ready_o),
        .data_o (fifo_instr),
        .valid_o(fifo_valid),
        .grant_i(instr_pop)
    );

    trdb_priority u_priority (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .instr_i      (fifo_instr),
        .instr_valid_i(fifo_valid),
        .instr_pop_o  (instr_pop),
        .map_cnt_i    (map_cnt),
        .map_full_i   (map_full),
        .shift_valid_o(shift_valid),
        .taken_o      (taken),
        .req_o        (req),
        .req_valid_o  (req_valid),
        .emit_ready_i (emit_ready)
    );

    trdb_branch_map u_branch_map (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .shift_valid_i(shift_valid),
        .taken_i      (taken),
        .flush_i      (map_flush),
        .map_o        (map_bits),
        .cnt_o        (map_cnt),
        .full_o       (map_full)
    );

    trdb_packet_emitter u_packet_emitter (
        .clk_i             (clk_i),
        .rst_ni            (rst_ni),
        .req_i             (req),
        .req_valid_i       (req_valid),
        .branch_map_i      (map_bits),
        .branch_map_cnt_i  (map_cnt),
        .emit_ready_o      (emit_ready),
        .branch_map_flush_o(map_flush),
        .packet_o          (packet_o),
        .packet_valid_o    (packet_valid_o),
        .packet_grant_i    (packet_grant_i)
    );

endmodule

// File: dv/tb_trdb.sv
// Testbench for the trace encoder: directed and random stimulus,
// reference model of the packet rules, packet checks and watchdog

`include "trdb_settings.svh"

module tb_trdb;
    import trdb_pkg::*;

    localparam int RandomInstrs   = 200;
    localparam int TotalInstrs    = 1 + 31 + 121 + 5 + RandomInstrs;
    localparam int ResetCycles    = 10;
    localparam int WatchdogCycles = ResetCycles + TotalInstrs * 20;

    typedef enum int {KIND_PLAIN, KIND_BRANCH, KIND_JUMP, KIND_EXC} kind_e;

    logic         clk_i;
    logic         rst_ni;
    trdb_instr_t  instr_i;
    logic         instr_valid_i;
    logic         instr_ready_o;
    trdb_packet_t packet_o;
    logic         packet_valid_o;
    logic         packet_grant_i;

    // Reference model state
    trdb_packet_t                    exp_q [$];
    logic [`TRDB_BRANCH_MAP_LEN-1:0] m_map;
    int                              m_cnt;
    logic                            m_first;

    logic [31:0]  rng_q;
    int           n_checks;
    int           n_errors;
    int           err_mark;
    logic         random_grant;
    logic         ready_low_seen;
    logic         hold_q;
    trdb_packet_t held_pkt_q;
    trdb_packet_t head_pkt;
    int           branch_runs [8] = '{1, 2, 9, 10, 17, 18, 25, 30};

    trdb_tracer dut (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .instr_i       (instr_i),
        .instr_valid_i (instr_valid_i),
        .instr_ready_o (instr_ready_o),
        .packet_o      (packet_o),
        .packet_valid_o(packet_valid_o),
        .packet_grant_i(packet_grant_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_q = xorshift32(rng_q);
        return rng_q;
    endfunction

    // Address bits also supply priv, cause and interrupt
    function automatic trdb_instr_t make_instr(input kind_e kind, input logic taken);
        trdb_instr_t ins;
        logic [31:0] a;
        a = next_rand();
        ins = '0;
        ins.iaddr     = {a[31:2], 2'b00};
        ins.priv      = a[5:4];
        ins.is_branch = (kind == KIND_BRANCH);
        ins.taken     = (kind == KIND_BRANCH) && taken;
        ins.is_jump   = (kind == KIND_JUMP);
        ins.exception = (kind == KIND_EXC);
        ins.interrupt = ins.exception && a[13];
        ins.cause     = ins.exception ? a[12:8] : '0;
        return ins;
    endfunction

    // Smallest allowed map field width that is not below the count
    function automatic int map_offset(input int cnt);
        int offsets [5] = '{1, 9, 17, 25, 31};
        int off;
        off = offsets[4];
        for (int i = 4; i >= 0; i--) begin
            if (offsets[i] >= cnt) off = offsets[i];
        end
        return off;
    endfunction

    function automatic trdb_packet_t branch_full_pkt(input logic [31:0] iaddr,
                                                     input logic with_addr);
        trdb_packet_t p;
        int           off;
        p = '0;
        off = map_offset(m_cnt);
        p.bits[1:0] = F_BRANCH_FULL;
        p.bits[6:2] = 5'(m_cnt);
        for (int i = 0; i < m_cnt; i++) begin
            p.bits[7 + i] = m_map[i];
        end
        if (with_addr) begin
            p.bits[7 + off +: 32] = iaddr;
            p.len = 7'(9 + off + 32);
        end else begin
            p.len = 7'(9 + off);
        end
        return p;
    endfunction

    function automatic trdb_packet_t sync_pkt(input trdb_instr_t ins, input logic exc);
        trdb_packet_t p;
        p = '0;
        p.bits[1:0]  = F_SYNC;
        p.bits[3:2]  = exc ? SF_EXCEPTION : SF_START;
        p.bits[5:4]  = ins.priv;
        p.bits[6]    = ins.is_branch;
        p.bits[38:7] = ins.iaddr;
        p.len        = 7'd39;
        if (exc) begin
            p.bits[43:39] = ins.cause;
            p.bits[44]    = ins.interrupt;
            p.len         = 7'd45;
        end
        return p;
    endfunction

    // Expected packets of one accepted instruction, in priority order
    task automatic model_instr(input trdb_instr_t ins);
        trdb_packet_t p;
        if (ins.exception) begin
            if (m_cnt != 0) exp_q.push_back(branch_full_pkt(ins.iaddr, 1'b1));
            exp_q.push_back(sync_pkt(ins, 1'b1));
            m_map = '0;
            m_cnt = 0;
        end else if (m_first) begin
            exp_q.push_back(sync_pkt(ins, 1'b0));
        end else if (ins.is_jump && m_cnt != 0) begin
            exp_q.push_back(branch_full_pkt(ins.iaddr, 1'b1));
            m_map = '0;
            m_cnt = 0;
        end else if (ins.is_jump) begin
            p = '0;
            p.bits[1:0]  = F_ADDR_ONLY;
            p.bits[33:2] = ins.iaddr;
            p.len        = 7'd34;
            exp_q.push_back(p);
        end else if (ins.is_branch) begin
            m_map[m_cnt] = ins.taken;
            m_cnt++;
            if (m_cnt == `TRDB_BRANCH_MAP_LEN) begin
                exp_q.push_back(branch_full_pkt('0, 1'b0));
                m_map = '0;
                m_cnt = 0;
            end
        end
        m_first = 1'b0;
    endtask

    task automatic check_value(input string name, input logic [78:0] got,
                               input logic [78:0] exp);
        n_checks++;
        assert (got === exp) else begin
            n_errors++;
            $display("[FAIL] %s: expected %0h, got %0h", name, exp, got);
        end
    endtask

    task automatic update_grant();
        logic [31:0] r;
        if (random_grant) begin
            r = next_rand();
            packet_grant_i = (r[2:0] == 3'd0);
        end
    endtask

    task automatic send_instr(input trdb_instr_t ins);
        @(negedge clk_i);
        update_grant();
        instr_i       = ins;
        instr_valid_i = 1'b1;
        while (!instr_ready_o) begin
            @(negedge clk_i);
            update_grant();
        end
    endtask

    // Stop input, let every expected packet drain, then report
    task automatic finish_test(input int num, input string name);
        @(negedge clk_i);
        instr_valid_i  = 1'b0;
        packet_grant_i = 1'b1;
        random_grant   = 1'b0;
        while (exp_q.size() != 0) @(negedge clk_i);
        $display("test %0d %-12s %0d errors", num, name, n_errors - err_mark);
        err_mark = n_errors;
    endtask

    // Model update on accepted instructions and packet comparison
    always @(posedge clk_i) begin
        if (rst_ni && instr_valid_i && instr_ready_o) model_instr(instr_i);
        if (rst_ni && !instr_ready_o && packet_valid_o && !packet_grant_i) begin
            ready_low_seen = 1'b1;
        end
        if (rst_ni && packet_valid_o && packet_grant_i) begin
            if (exp_q.size() == 0) begin
                n_checks++;
                n_errors++;
                $display("A packet arrived while the model expected none");
            end else begin
                head_pkt = exp_q.pop_front();
                check_value("packet_o.len", packet_o.len, head_pkt.len);
                check_value("packet_o.bits", packet_o.bits, head_pkt.bits);
            end
        end
    end

    // A stalled packet stays valid and unchanged
    always @(posedge clk_i) begin
        if (rst_ni && hold_q) begin
            check_value("packet_valid_o", packet_valid_o, 1'b1);
            check_value("packet_o", packet_o, held_pkt_q);
        end
        hold_q     <= rst_ni && packet_valid_o && !packet_grant_i;
        held_pkt_q <= packet_o;
    end

    initial begin
        repeat (WatchdogCycles) @(posedge clk_i);
        $display("Watchdog expired after %0d cycles with packets outstanding", WatchdogCycles);
        $display("Test failed");
        $finish;
    end

    initial begin
        logic [31:0] r;
        kind_e       kind;
        rng_q          = 32'h69a2;
        m_map          = '0;
        m_cnt          = 0;
        m_first        = 1'b1;
        n_checks       = 0;
        n_errors       = 0;
        err_mark       = 0;
        random_grant   = 1'b0;
        ready_low_seen = 1'b0;
        hold_q         = 1'b0;
        rst_ni         = 1'b0;
        instr_i        = '0;
        instr_valid_i  = 1'b0;
        packet_grant_i = 1'b1;
        repeat (ResetCycles) @(negedge clk_i);
        rst_ni = 1'b1;

        @(negedge clk_i);
        check_value("packet_valid_o", packet_valid_o, 1'b0);
        check_value("instr_ready_o", instr_ready_o, 1'b1);
        send_instr(make_instr(KIND_BRANCH, 1'b1));
        finish_test(1, "sync start");

        for (int i = 0; i < `TRDB_BRANCH_MAP_LEN; i++) begin
            r = next_rand();
            send_instr(make_instr(KIND_BRANCH, r[0]));
        end
        finish_test(2, "full map");

        // Runs chosen to hit every map offset
        foreach (branch_runs[k]) begin
            for (int i = 0; i < branch_runs[k]; i++) begin
                r = next_rand();
                send_instr(make_instr(KIND_BRANCH, r[0]));
            end
            send_instr(make_instr(KIND_JUMP, 1'b0));
        end
        send_instr(make_instr(KIND_JUMP, 1'b0));
        finish_test(3, "jump");

        repeat (3) begin
            r = next_rand();
            send_instr(make_instr(KIND_BRANCH, r[0]));
        end
        send_instr(make_instr(KIND_EXC, 1'b0));
        send_instr(make_instr(KIND_EXC, 1'b0));
        finish_test(4, "exception");

        random_grant   = 1'b1;
        ready_low_seen = 1'b0;
        for (int i = 0; i < RandomInstrs; i++) begin
            r = next_rand();
            case (r[2:0])
                3'd4, 3'd5: kind = KIND_JUMP;
                3'd6:       kind = KIND_EXC;
                3'd7:       kind = KIND_PLAIN;
                default:    kind = KIND_BRANCH;
            endcase
            send_instr(make_instr(kind, r[3]));
        end
        n_checks++;
        assert (ready_low_seen) else begin
            n_errors++;
            $display("instr_ready_o never went low while packets were held back");
        end
        finish_test(5, "backpressure");

        $display("checks: %0d passed, %0d failed", n_checks - n_errors, n_errors);
        if (n_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: compile.f
+incdir+verilog
verilog/trdb_pkg.sv
verilog/trdb_stream_fifo.sv
verilog/trdb_branch_map.sv
verilog/trdb_priority.sv
verilog/trdb_packet_emitter.sv
verilog/trdb_tracer.sv
dv/tb_trdb.sv

// File: Makefile
TOOL     ?= verilator
FLAGS    ?= --binary -Wno-fatal -j 0
TOP      ?= tb_trdb
FILELIST ?= compile.f
BUILD    ?= obj_dir
LOG      ?= sim.log
PASS_MSG := Test completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
